/* include/dcache_config.svh */
// data cache configuration
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// log2 of the number of lines, one 64-bit word per line
`define DCACHE_INDEX_BITS 5

// pending memory commands, stores and load misses together
`define CMD_QUEUE_DEPTH 8

// memory transaction tags, tag 0 is reserved for "no tag"
`define MEM_TAG_COUNT 16

// byte address width on the memory bus
`define ADDR_BITS 32

`endif

/* design/mem_bus_pkg.sv */
// memory bus types
`include "dcache_config.svh"

package mem_bus_pkg;

  typedef logic [`ADDR_BITS-1:0] addr_t;          // byte address
  typedef logic [63:0] word_t;                      // one line, one word
  typedef logic [$clog2(`MEM_TAG_COUNT)-1:0] mem_tag_t;

  // command encoding seen by the memory
  typedef enum logic [1:0] {
    BUS_NONE  = 2'd0,
    BUS_LOAD  = 2'd1,
    BUS_STORE = 2'd2
  } bus_command_t;

  // request driven toward memory each cycle
  typedef struct packed {
    bus_command_t command;
    addr_t        addr;
    word_t        data;   // store data, zero for loads
  } mem_req_t;

endpackage

/* design/dcache_pkg.sv */
// cache side types
`include "dcache_config.svh"

package dcache_pkg;

  // address = {tag, index, 3-bit byte offset}
  typedef logic [`DCACHE_INDEX_BITS-1:0] cache_index_t;
  typedef logic [`ADDR_BITS-`DCACHE_INDEX_BITS-4:0] cache_tag_t;

  typedef logic [6:0] phys_reg_t;
  typedef logic [4:0] arch_reg_t;

  typedef struct packed {
    mem_bus_pkg::addr_t addr;
    phys_reg_t          pr;
    arch_reg_t          ar;
  } load_req_t;

  typedef struct packed {
    mem_bus_pkg::addr_t addr;
    mem_bus_pkg::word_t data;
  } store_req_t;

  // one result on the common data bus
  typedef struct packed {
    phys_reg_t          pr;
    arch_reg_t          ar;
    mem_bus_pkg::word_t data;
  } cdb_packet_t;

  typedef struct packed {
    mem_bus_pkg::mem_req_t req;
    phys_reg_t             pr;   // destination, loads only
    arch_reg_t             ar;
  } cmd_entry_t;

  typedef struct packed {
    cache_index_t index;
    cache_tag_t   tag;
    phys_reg_t    pr;
    arch_reg_t    ar;
    logic         stale;  // a later store hit this line
  } mshr_entry_t;

endpackage

/* design/dcache_cachemem.sv */
// direct mapped line array
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_cachemem (
  input  logic                     clock,
  input  logic                     reset,
  input  dcache_pkg::cache_index_t rd_index,
  input  dcache_pkg::cache_tag_t   rd_tag,
  output logic                     rd_hit,
  output mem_bus_pkg::word_t       rd_data,
  input  logic                     fill_en,
  input  dcache_pkg::cache_index_t fill_index,
  input  dcache_pkg::cache_tag_t   fill_tag,
  input  mem_bus_pkg::word_t       fill_data,
  input  logic                     inval_en,
  input  dcache_pkg::cache_index_t inval_index,
  input  dcache_pkg::cache_tag_t   inval_tag
);

  localparam int LINES = 1 << `DCACHE_INDEX_BITS;

  dcache_pkg::cache_tag_t line_tag [LINES];
  mem_bus_pkg::word_t     line_data [LINES];
  logic [LINES-1:0]       line_valid;
  logic                   inval_hit;
  logic                   fill_write;

  assign rd_hit  = line_valid[rd_index] && (line_tag[rd_index] == rd_tag);
  assign rd_data = line_data[rd_index];

  assign inval_hit = inval_en && line_valid[inval_index] && (line_tag[inval_index] == inval_tag);
  // a store to the very line being filled cancels the fill
  assign fill_write = fill_en && !(inval_en && (inval_index == fill_index) &&
                                   (inval_tag == fill_tag));

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      line_valid <= '0;
    end
    else
    begin
      if (inval_hit)
        line_valid[inval_index] <= 1'b0;
      if (fill_write)
        line_valid[fill_index] <= 1'b1;  // different tag replaces the line
    end
  end

  always_ff @(posedge clock)
  begin
    if (fill_write)
    begin
      line_tag[fill_index]  <= fill_tag;
      line_data[fill_index] <= fill_data;
    end
  end

endmodule

/* design/dcache_cmd_queue.sv */
// memory command fifo
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_cmd_queue (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   push,
  input  dcache_pkg::cmd_entry_t push_entry,
  output logic                   full,
  output logic                   empty,
  output dcache_pkg::cmd_entry_t head,
  input  logic                   pop
);

  localparam int DEPTH = `CMD_QUEUE_DEPTH;
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_BITS-1:0] ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] count_t;

  dcache_pkg::cmd_entry_t slots [DEPTH];
  ptr_t                   head_ptr;
  ptr_t                   tail_ptr;
  count_t                 count;
  logic                   do_push;
  logic                   do_pop;

  function automatic ptr_t next_ptr(input ptr_t ptr);
    return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == count_t'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_comb
  begin
    head = slots[head_ptr];
    if (empty)
    begin
      head = '0;
      head.req.command = mem_bus_pkg::BUS_NONE;  // idle bus
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end
    else
    begin
      if (do_push)
        tail_ptr <= next_ptr(tail_ptr);
      if (do_pop)
        head_ptr <= next_ptr(head_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clock)
  begin
    if (do_push)
      slots[tail_ptr] <= push_entry;
  end

endmodule

/* design/dcache_mshr.sv */
// miss table indexed by memory tag
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_mshr (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     alloc_en,
  input  mem_bus_pkg::mem_tag_t    alloc_tag,
  input  dcache_pkg::mshr_entry_t  alloc_entry,
  input  logic                     store_en,
  input  dcache_pkg::cache_index_t store_index,
  input  dcache_pkg::cache_tag_t   store_tag,
  input  mem_bus_pkg::mem_tag_t    ret_tag,
  output logic                     ret_hit,
  output dcache_pkg::mshr_entry_t  ret_entry,
  output logic                     busy
);

  localparam int SLOTS = `MEM_TAG_COUNT;

  dcache_pkg::mshr_entry_t slots [SLOTS];
  logic [SLOTS-1:0]        occupied;

  // tag 0 never names a transaction
  assign ret_hit   = (ret_tag != '0) && occupied[ret_tag];
  assign ret_entry = slots[ret_tag];
  assign busy      = |occupied;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      occupied <= '0;
    end
    else
    begin
      if (ret_hit)
        occupied[ret_tag] <= 1'b0;
      if (alloc_en)
        occupied[alloc_tag] <= 1'b1;  // a freed tag may be reissued at once
    end
  end

  always_ff @(posedge clock)
  begin
    for (int i = 0; i < SLOTS; i++)
    begin
      if (store_en && occupied[i] && (slots[i].index == store_index) &&
          (slots[i].tag == store_tag))
        slots[i].stale <= 1'b1;
    end
    if (alloc_en)
      slots[alloc_tag] <= alloc_entry;
  end

endmodule

/* design/dcache.sv */
// data cache controller
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     load_valid,
  output logic                     load_ready,
  input  dcache_pkg::load_req_t    load_req,
  input  logic                     store_valid,
  output logic                     store_ready,
  input  dcache_pkg::store_req_t   store_req,
  input  logic                     halt,
  output logic                     halted,
  output mem_bus_pkg::mem_req_t    mem_req,
  input  mem_bus_pkg::mem_tag_t    mem_response,
  input  mem_bus_pkg::mem_tag_t    mem_tag,
  input  mem_bus_pkg::word_t       mem_rdata,
  output dcache_pkg::cache_index_t lookup_index,
  output dcache_pkg::cache_tag_t   lookup_tag,
  input  logic                     lookup_hit,
  input  mem_bus_pkg::word_t       lookup_data,
  output logic                     fill_en,
  output dcache_pkg::cache_index_t fill_index,
  output dcache_pkg::cache_tag_t   fill_tag,
  output mem_bus_pkg::word_t       fill_data,
  output logic                     inval_en,
  output dcache_pkg::cache_index_t inval_index,
  output dcache_pkg::cache_tag_t   inval_tag,
  output logic                     cdb_valid,
  output dcache_pkg::cdb_packet_t  cdb
);

  localparam int IDX_LO = 3;
  localparam int TAG_LO = IDX_LO + `DCACHE_INDEX_BITS;

  dcache_pkg::cmd_entry_t   push_entry;
  dcache_pkg::cmd_entry_t   queue_head;
  dcache_pkg::mshr_entry_t  alloc_entry;
  dcache_pkg::mshr_entry_t  ret_entry;
  dcache_pkg::cache_index_t head_index;
  dcache_pkg::cache_tag_t   head_tag;
  logic queue_full;
  logic queue_empty;
  logic store_fire;
  logic load_fire;
  logic load_hit;
  logic pop;
  logic head_is_load;
  logic head_is_store;
  logic ret_hit;
  logic mshr_busy;
  logic halt_seen;
  logic [$clog2(`CMD_QUEUE_DEPTH+1)-1:0] stores_queued;  // accepted, not yet on the bus

  function automatic dcache_pkg::cache_index_t addr_index(input mem_bus_pkg::addr_t addr);
    return addr[TAG_LO-1:IDX_LO];
  endfunction

  function automatic dcache_pkg::cache_tag_t addr_tag(input mem_bus_pkg::addr_t addr);
    return addr[`ADDR_BITS-1:TAG_LO];
  endfunction

  // stores first, and a returning miss owns the result bus
  assign store_ready = !queue_full;
  assign load_ready  = !queue_full && !store_valid && !ret_hit;
  assign store_fire  = store_valid && store_ready;
  assign load_fire   = load_valid && load_ready;

  assign lookup_index = addr_index(load_req.addr);
  assign lookup_tag   = addr_tag(load_req.addr);
  assign load_hit     = load_fire && lookup_hit;

  assign inval_en    = store_fire;
  assign inval_index = addr_index(store_req.addr);
  assign inval_tag   = addr_tag(store_req.addr);

  always_comb
  begin
    push_entry = '0;
    if (store_fire)
    begin
      push_entry.req.command = mem_bus_pkg::BUS_STORE;
      push_entry.req.addr    = store_req.addr;
      push_entry.req.data    = store_req.data;
    end
    else
    begin
      push_entry.req.command = mem_bus_pkg::BUS_LOAD;
      push_entry.req.addr    = load_req.addr;
      push_entry.pr          = load_req.pr;
      push_entry.ar          = load_req.ar;
    end
  end

  // head pops on the edge where memory hands out a tag
  assign mem_req       = queue_head.req;
  assign pop           = (mem_response != '0) && !queue_empty;
  assign head_is_load  = (queue_head.req.command == mem_bus_pkg::BUS_LOAD);
  assign head_is_store = (queue_head.req.command == mem_bus_pkg::BUS_STORE);
  assign head_index    = addr_index(queue_head.req.addr);
  assign head_tag      = addr_tag(queue_head.req.addr);
  assign alloc_entry   = '{index: head_index, tag: head_tag, pr: queue_head.pr,
                           ar: queue_head.ar, stale: 1'b0};

  // misses issued ahead of a queued store would refill old data
  assign fill_en    = ret_hit && !ret_entry.stale && (stores_queued == '0);
  assign fill_index = ret_entry.index;
  assign fill_tag   = ret_entry.tag;
  assign fill_data  = mem_rdata;

  dcache_cmd_queue cmd_queue_i (
    .clock      (clock),
    .reset      (reset),
    .push       (store_fire || (load_fire && !lookup_hit)),
    .push_entry (push_entry),
    .full       (queue_full),
    .empty      (queue_empty),
    .head       (queue_head),
    .pop        (pop)
  );

  dcache_mshr mshr_i (
    .clock       (clock),
    .reset       (reset),
    .alloc_en    (pop && head_is_load),
    .alloc_tag   (mem_response),
    .alloc_entry (alloc_entry),
    .store_en    (pop && head_is_store),  // stale marking as the store reaches memory
    .store_index (head_index),
    .store_tag   (head_tag),
    .ret_tag     (mem_tag),
    .ret_hit     (ret_hit),
    .ret_entry   (ret_entry),
    .busy        (mshr_busy)
  );

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      stores_queued <= '0;
      cdb_valid     <= 1'b0;
      halt_seen     <= 1'b0;
      halted        <= 1'b0;
    end
    else
    begin
      case ({store_fire, pop && head_is_store})
        2'b10:   stores_queued <= stores_queued + 1'b1;
        2'b01:   stores_queued <= stores_queued - 1'b1;
        default: stores_queued <= stores_queued;
      endcase
      cdb_valid <= ret_hit || load_hit;
      halt_seen <= halt_seen || halt;
      halted    <= halted || (halt_seen && queue_empty && !mshr_busy);  // sticky
    end
  end

  always_ff @(posedge clock)
  begin
    if (ret_hit)
      cdb <= '{pr: ret_entry.pr, ar: ret_entry.ar, data: mem_rdata};
    else if (load_hit)
      cdb <= '{pr: load_req.pr, ar: load_req.ar, data: lookup_data};
  end

endmodule

/* design/dcache_top.sv */
// data cache with its line array
`timescale 1ns/1ps

module dcache_top (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    load_valid,
  output logic                    load_ready,
  input  dcache_pkg::load_req_t   load_req,
  input  logic                    store_valid,
  output logic                    store_ready,
  input  dcache_pkg::store_req_t  store_req,
  input  logic                    halt,
  output logic                    halted,
  output mem_bus_pkg::mem_req_t   mem_req,
  input  mem_bus_pkg::mem_tag_t   mem_response,
  input  mem_bus_pkg::mem_tag_t   mem_tag,
  input  mem_bus_pkg::word_t      mem_rdata,
  output logic                    cdb_valid,
  output dcache_pkg::cdb_packet_t cdb
);

  dcache_pkg::cache_index_t lookup_index;
  dcache_pkg::cache_tag_t   lookup_tag;
  logic                     lookup_hit;
  mem_bus_pkg::word_t       lookup_data;
  logic                     fill_en;
  dcache_pkg::cache_index_t fill_index;
  dcache_pkg::cache_tag_t   fill_tag;
  mem_bus_pkg::word_t       fill_data;
  logic                     inval_en;
  dcache_pkg::cache_index_t inval_index;
  dcache_pkg::cache_tag_t   inval_tag;

  // names match the controller ports one to one
  dcache dcache_i (.*);

  dcache_cachemem cachemem_i (
    .clock       (clock),
    .reset       (reset),
    .rd_index    (lookup_index),
    .rd_tag      (lookup_tag),
    .rd_hit      (lookup_hit),
    .rd_data     (lookup_data),
    .fill_en     (fill_en),
    .fill_index  (fill_index),
    .fill_tag    (fill_tag),
    .fill_data   (fill_data),
    .inval_en    (inval_en),
    .inval_index (inval_index),
    .inval_tag   (inval_tag)
  );

endmodule

/* dv/mem_model.sv */
// behavioral tagged memory
`timescale 1ns/1ps
`include "dcache_config.svh"

module mem_model #(
  parameter mem_bus_pkg::word_t FILL        = 64'h0,
  parameter int                 MAX_LATENCY = 12
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  stall,  // refuse every command
  input  mem_bus_pkg::mem_req_t mem_req,
  output mem_bus_pkg::mem_tag_t mem_response,
  output mem_bus_pkg::mem_tag_t mem_tag,
  output mem_bus_pkg::word_t    mem_rdata
);

  localparam int SLOTS = `MEM_TAG_COUNT;

  mem_bus_pkg::word_t    image [mem_bus_pkg::addr_t];
  mem_bus_pkg::word_t    held_data [SLOTS];
  int unsigned           due [SLOTS];
  logic [SLOTS-1:0]      busy;
  logic                  accept_roll;
  mem_bus_pkg::mem_tag_t free_tag;
  int unsigned           rng;
  int unsigned           cycle;

  function automatic int unsigned xorshift(input int unsigned x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic mem_bus_pkg::word_t read_word(input mem_bus_pkg::addr_t addr);
    if (image.exists(addr))
      return image[addr];
    return {addr, addr} ^ FILL;  // never written
  endfunction

  initial
  begin
    accept_roll = 1'b0;
    mem_tag     = '0;
    mem_rdata   = '0;
  end

  // lowest tag with no load in flight or 0 when all are taken
  always_comb
  begin
    free_tag = '0;
    for (int i = SLOTS - 1; i > 0; i--)
      if (!busy[i])
        free_tag = mem_bus_pkg::mem_tag_t'(i);
  end

  assign mem_response = (mem_req.command != mem_bus_pkg::BUS_NONE && !stall && accept_roll)
                        ? free_tag : '0;

  always @(posedge clock)
  begin
    int unsigned start;
    int          slot;
    int          picked;
    if (reset)
    begin
      rng = 35;
      cycle = 0;
      busy        <= '0;
      accept_roll <= 1'b0;
      mem_tag     <= '0;
      mem_rdata   <= '0;
    end
    else
    begin
      cycle++;
      rng = xorshift(rng);
      accept_roll <= (rng[1:0] != 2'b00);  // three cycles in four
      if (mem_response != '0)
      begin
        if (mem_req.command == mem_bus_pkg::BUS_STORE)
          image[mem_req.addr] = mem_req.data;
        else
        begin
          held_data[mem_response] = read_word(mem_req.addr);
          due[mem_response] = cycle + 2 + (rng >> 8) % (MAX_LATENCY - 1);
          busy[mem_response] <= 1'b1;
        end
      end
      // random scan start gives out of order returns
      picked = 0;
      start = (rng >> 16) % SLOTS;
      for (int k = 0; k < SLOTS; k++)
      begin
        slot = (start + k) % SLOTS;
        if (picked == 0 && busy[slot] && cycle >= due[slot])
          picked = slot;
      end
      mem_tag   <= mem_bus_pkg::mem_tag_t'(picked);
      mem_rdata <= (picked != 0) ? held_data[picked] : '0;
      if (picked != 0)
        busy[picked] <= 1'b0;
    end
  end

endmodule

/* dv/dcache_tb.sv */
// data cache testbench
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_tb;

  localparam mem_bus_pkg::word_t FILL = 64'h5a5a_c3c3_0f0f_9696;
  localparam int CLOCK_PERIOD = 10;
  localparam int MAX_LATENCY  = 12;
  localparam int RESET_CYCLES = 16;
  localparam int STALL_CYCLES = 20;
  localparam int HOLD_CYCLES  = 10;
  localparam int DEPTH        = `CMD_QUEUE_DEPTH;
  // loads and stores over all six tests
  localparam int COMMANDS        = 2 + 2 + 6 + 3 + (DEPTH + 1) + 4;
  localparam int COMMAND_CYCLES  = 4 * (MAX_LATENCY + 4);
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + STALL_CYCLES + HOLD_CYCLES +
                                   COMMANDS * COMMAND_CYCLES;

  logic                    clock;
  logic                    reset;
  logic                    load_valid;
  logic                    load_ready;
  dcache_pkg::load_req_t   load_req;
  logic                    store_valid;
  logic                    store_ready;
  dcache_pkg::store_req_t  store_req;
  logic                    halt;
  logic                    halted;
  mem_bus_pkg::mem_req_t   mem_req;
  mem_bus_pkg::mem_tag_t   mem_response;
  mem_bus_pkg::mem_tag_t   mem_tag;
  mem_bus_pkg::word_t      mem_rdata;
  logic                    cdb_valid;
  dcache_pkg::cdb_packet_t cdb;
  logic                    mem_stall;

  // reference memory image and per phys reg results still due
  mem_bus_pkg::word_t    ref_image [mem_bus_pkg::addr_t];
  mem_bus_pkg::word_t    exp_data [128];
  dcache_pkg::arch_reg_t exp_ar [128];
  logic [127:0]          pending;
  int                    outstanding;
  int                    checks;
  int                    errors;
  logic                  halt_sent;
  logic                  halted_seen;

  dcache_top dcache_top_i (.*);

  mem_model #(
    .FILL        (FILL),
    .MAX_LATENCY (MAX_LATENCY)
  ) mem_model_i (
    .clock        (clock),
    .reset        (reset),
    .stall        (mem_stall),
    .mem_req      (mem_req),
    .mem_response (mem_response),
    .mem_tag      (mem_tag),
    .mem_rdata    (mem_rdata)
  );

  initial
  begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  task automatic report_failure(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
    errors++;
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
  endtask

  function automatic mem_bus_pkg::word_t expected_word(input mem_bus_pkg::addr_t address);
    if (ref_image.exists(address))
      return ref_image[address];
    return {address, address} ^ FILL;  // initial memory contents
  endfunction

  // returns on the edge after acceptance
  task automatic send_load(input mem_bus_pkg::addr_t address, input dcache_pkg::phys_reg_t pr,
                           input dcache_pkg::arch_reg_t ar, input logic expect_hit);
    load_valid <= 1'b1;
    load_req   <= '{addr: address, pr: pr, ar: ar};
    do
      @(posedge clock);
    while (!load_ready);
    exp_data[pr] = expected_word(address);
    exp_ar[pr]   = ar;
    pending[pr]  = 1'b1;
    outstanding++;
    load_valid <= 1'b0;
    @(posedge clock);
    checks++;
    if (expect_hit)
    begin
      assert (cdb_valid && cdb.pr == pr)
      else report_failure($sformatf("load hit for pr %0d did not return the next cycle", pr));
    end
    else
    begin
      assert (!(cdb_valid && cdb.pr == pr))
      else report_failure($sformatf("load for pr %0d returned as a hit", pr));
    end
  endtask

  task automatic send_store(input mem_bus_pkg::addr_t address, input mem_bus_pkg::word_t data);
    store_valid <= 1'b1;
    store_req   <= '{addr: address, data: data};
    do
      @(posedge clock);
    while (!store_ready);
    ref_image[address] = data;
    store_valid <= 1'b0;
  endtask

  // resumes on the edge after the last result was taken
  task automatic wait_results();
    wait (outstanding == 0);
    @(posedge clock);
  endtask

  task automatic check_packet(input dcache_pkg::cdb_packet_t packet);
    checks++;
    assert (pending[packet.pr])
    else report_failure($sformatf("unexpected or repeated result for pr %0d", packet.pr));
    if (pending[packet.pr])
    begin
      assert (packet.data == exp_data[packet.pr])
      else report_mismatch("cdb.data", packet.data, exp_data[packet.pr]);
      assert (packet.ar == exp_ar[packet.pr])
      else report_mismatch("cdb.ar", 64'(packet.ar), 64'(exp_ar[packet.pr]));
      pending[packet.pr] = 1'b0;
      outstanding--;
    end
  endtask

  // result bus and halt monitor
  always @(posedge clock)
  begin
    if (!reset)
    begin
      if (halted_seen)
      begin
        checks++;
        assert (halted) else report_failure("halted fell before reset");
      end
      if (halted)
      begin
        checks++;
        assert (halt_sent && outstanding == 0)
        else report_failure("halted rose without a halt request or with results still due");
        halted_seen = 1'b1;
      end
      if (cdb_valid)
        check_packet(cdb);
    end
  end

  task automatic test_miss_then_hit();
    send_load(32'h0000_1008, 7'd1, 5'd1, 1'b0);
    wait_results();
    send_load(32'h0000_1008, 7'd2, 5'd2, 1'b1);
    wait_results();
  endtask

  task automatic test_store_then_load();
    send_store(32'h0000_1008, 64'h1111_2222_3333_4444);
    send_load(32'h0000_1008, 7'd3, 5'd3, 1'b0);  // line was invalidated
    wait_results();
  endtask

  task automatic test_multiple_misses();
    for (int i = 0; i < 6; i++)
      send_load(mem_bus_pkg::addr_t'(32'h0002_0000 + i * 8), dcache_pkg::phys_reg_t'(10 + i),
                dcache_pkg::arch_reg_t'(i), 1'b0);
    wait_results();
  endtask

  task automatic test_stale_fill();
    send_load(32'h0003_0040, 7'd20, 5'd20, 1'b0);  // old value expected
    send_store(32'h0003_0040, 64'hdead_beef_0bad_f00d);
    wait_results();
    send_load(32'h0003_0040, 7'd21, 5'd21, 1'b0);
    wait_results();
  endtask

  task automatic test_back_pressure();
    mem_stall <= 1'b1;
    for (int i = 0; i < DEPTH; i++)
      send_load(mem_bus_pkg::addr_t'(32'h0004_0000 + i * 8), dcache_pkg::phys_reg_t'(30 + i),
                dcache_pkg::arch_reg_t'(i), 1'b0);
    load_valid <= 1'b1;
    load_req   <= '{addr: 32'h0004_0000 + DEPTH * 8, pr: 7'(30 + DEPTH), ar: 5'(DEPTH)};
    repeat (STALL_CYCLES)
    begin
      @(posedge clock);
      checks++;
      assert (!load_ready && !store_ready)
      else report_failure("ready stayed high with the command queue full");
    end
    mem_stall <= 1'b0;
    send_load(32'h0004_0000 + DEPTH * 8, 7'(30 + DEPTH), 5'(DEPTH), 1'b0);
    wait_results();
  endtask

  task automatic test_halt();
    for (int i = 0; i < 4; i++)
      send_load(mem_bus_pkg::addr_t'(32'h0005_0000 + i * 8), dcache_pkg::phys_reg_t'(40 + i),
                dcache_pkg::arch_reg_t'(i), 1'b0);
    halt <= 1'b1;
    halt_sent = 1'b1;
    while (!halted)
      @(posedge clock);
    repeat (HOLD_CYCLES) @(posedge clock);  // monitor watches it stay high
  endtask

  initial
  begin
    reset       = 1'b1;
    load_valid  = 1'b0;
    load_req    = '0;
    store_valid = 1'b0;
    store_req   = '0;
    halt        = 1'b0;
    mem_stall   = 1'b0;
    pending     = '0;
    outstanding = 0;
    checks      = 0;
    errors      = 0;
    halt_sent   = 1'b0;
    halted_seen = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    checks++;
    assert (!halted && !cdb_valid && mem_req.command == mem_bus_pkg::BUS_NONE)
    else report_failure("outputs not idle after reset");
    test_miss_then_hit();
    test_store_then_load();
    test_multiple_misses();
    test_stale_fill();
    test_back_pressure();
    test_halt();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  // watchdog sized from the command count
  initial
  begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("Error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* src.f */
+incdir+include
design/mem_bus_pkg.sv
design/dcache_pkg.sv
design/dcache_cachemem.sv
design/dcache_cmd_queue.sv
design/dcache_mshr.sv
design/dcache.sv
design/dcache_top.sv
dv/mem_model.sv
dv/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the data cache testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --assert --timing -Wno-fatal --top-module dcache_tb \
  -f src.f -Mdir "$BUILD_DIR" -o dcache_tb_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"$BUILD_DIR/dcache_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
